// ==== Makefile ====
# Verilator flow for the safety wrapper testbench
VERILATOR ?= verilator
TOP       ?= tb_safe_cpu_wrapper
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) hdl/safe_defs.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+hdl
hdl/safe_pkg.sv
hdl/tmr_voter.sv
hdl/dmr_comparator.sv
hdl/wfi_isolator.sv
hdl/redundancy_ctrl.sv
hdl/req_steer.sv
hdl/resp_steer.sv
hdl/safe_cpu_wrapper.sv
verif/tb_safe_cpu_wrapper.sv

// ==== hdl/dmr_comparator.sv ====
// Dual-lockstep check of one channel
// Only the master request goes on; the partner request is only compared
`timescale 1ns/1ps

module dmr_comparator (
  input  safe_pkg::bus_req_t master_req_i,
  input  safe_pkg::bus_req_t partner_req_i,
  output safe_pkg::bus_req_t req_o,
  output logic               error_o
);

  logic req_diff;
  logic addr_diff;
  logic wr_diff;

  // Master owns the bus
  assign req_o = master_req_i;

  // Handshake and direction
  assign req_diff = (master_req_i.req != partner_req_i.req) ||
                    (master_req_i.we != partner_req_i.we);

  assign addr_diff = (master_req_i.addr != partner_req_i.addr);

  // Write payload incl. byte enables
  assign wr_diff = (master_req_i.be != partner_req_i.be) ||
                   (master_req_i.wdata != partner_req_i.wdata);

  assign error_o = req_diff || addr_diff || wr_diff;

endmodule

// ==== hdl/redundancy_ctrl.sv ====
// Master latch and route decode for the wrapper
// master_i is taken only after a cycle with all harts asleep
// The DMR pair is used as given, it is not latched
`timescale 1ns/1ps
`include "safe_defs.svh"

module redundancy_ctrl (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  safe_pkg::redund_mode_e               mode_i,
  input  safe_pkg::hart_mask_t                 master_i,
  input  safe_pkg::hart_mask_t                 dmr_pair_i,
  input  safe_pkg::hart_mask_t                 sleep_i,
  output safe_pkg::hart_mask_t                 master_o,
  output safe_pkg::route_e [`SAFE_NHARTS-1:0] route_o,
  output safe_pkg::hart_mask_t                 isolate_o
);

  safe_pkg::hart_mask_t master_q;

  // Change master only while every hart sits in wfi
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      master_q <= `SAFE_MASTER_RST;
    end else if (&sleep_i) begin
      master_q <= master_i;
    end
  end

  assign master_o = master_q;

  // Per-hart response source
  always_comb begin
    for (int i = 0; i < `SAFE_NHARTS; i++) begin
      route_o[i]   = safe_pkg::ROUTE_OWN;
      isolate_o[i] = 1'b0;
      case (mode_i)
        safe_pkg::MODE_TMR: begin
          route_o[i] = safe_pkg::ROUTE_MASTER;
        end
        safe_pkg::MODE_DMR: begin
          if (dmr_pair_i[i]) begin
            route_o[i] = safe_pkg::ROUTE_MASTER;
          end else begin
            // Third hart parked behind the isolator
            route_o[i]   = safe_pkg::ROUTE_ISOLATE;
            isolate_o[i] = 1'b1;
          end
        end
        default: begin
          route_o[i] = safe_pkg::ROUTE_OWN;
        end
      endcase
    end
  end

  a_master_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot(master_q));

  // Pair of two that holds the current master
  a_dmr_pair_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode_i == safe_pkg::MODE_DMR) |->
      (($countones(dmr_pair_i) == 2) && |(dmr_pair_i & master_q)));

endmodule

// ==== hdl/req_steer.sv ====
// Places hart requests on the bus ports according to the mode
// In lockstep modes only the master's port carries traffic
// TMR error id is the union of the per-channel dissenters
`timescale 1ns/1ps
`include "safe_defs.svh"

module req_steer (
  input  safe_pkg::redund_mode_e                 mode_i,
  input  safe_pkg::hart_mask_t                   master_i,
  input  safe_pkg::hart_mask_t                   dmr_pair_i,
  input  safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] hart_instr_req_i,
  input  safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] hart_data_req_i,
  output safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] bus_instr_req_o,
  output safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] bus_data_req_o,
  output logic                                   tmr_error_o,
  output safe_pkg::hart_mask_t                   tmr_error_id_o,
  output logic                                   dmr_error_o
);

  // Index 0 is instruction, 1 is data
  safe_pkg::bus_req_t [1:0][`SAFE_NHARTS-1:0] hart_req;
  safe_pkg::bus_req_t [1:0][`SAFE_NHARTS-1:0] bus_req;
  logic [1:0]                                 tmr_err;
  safe_pkg::hart_mask_t [1:0]                 tmr_err_id;
  logic [1:0]                                 dmr_err;
  safe_pkg::hart_mask_t                       partner;

  // Partner is the pair bit that is not the master
  assign partner = dmr_pair_i & ~master_i;

  assign hart_req[0] = hart_instr_req_i;
  assign hart_req[1] = hart_data_req_i;

  for (genvar ch = 0; ch < 2; ch++) begin : gen_chan
    safe_pkg::bus_req_t                    master_req;
    safe_pkg::bus_req_t                    partner_req;
    safe_pkg::bus_req_t                    voted;
    safe_pkg::bus_req_t                    compared;
    safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] bus_sel;

    always_comb begin
      master_req  = '0;
      partner_req = '0;
      for (int h = 0; h < `SAFE_NHARTS; h++) begin
        if (master_i[h]) begin
          master_req = hart_req[ch][h];
        end
        if (partner[h]) begin
          partner_req = hart_req[ch][h];
        end
      end
    end

    tmr_voter u_tmr_voter (
      .req_i      (hart_req[ch]),
      .voted_o    (voted),
      .error_o    (tmr_err[ch]),
      .error_id_o (tmr_err_id[ch])
    );

    dmr_comparator u_dmr_comparator (
      .master_req_i  (master_req),
      .partner_req_i (partner_req),
      .req_o         (compared),
      .error_o       (dmr_err[ch])
    );

    // Non-master ports stay quiet in lockstep
    always_comb begin
      bus_sel = '0;
      for (int h = 0; h < `SAFE_NHARTS; h++) begin
        case (mode_i)
          safe_pkg::MODE_TMR: begin
            if (master_i[h]) begin
              bus_sel[h] = voted;
            end
          end
          safe_pkg::MODE_DMR: begin
            if (master_i[h]) begin
              bus_sel[h] = compared;
            end
          end
          default: begin
            bus_sel[h] = hart_req[ch][h];
          end
        endcase
      end
    end

    assign bus_req[ch] = bus_sel;
  end

  assign bus_instr_req_o = bus_req[0];
  assign bus_data_req_o  = bus_req[1];

  // Errors only count in their own mode
  assign tmr_error_o    = (mode_i == safe_pkg::MODE_TMR) && (|tmr_err);
  assign tmr_error_id_o = (mode_i == safe_pkg::MODE_TMR) ? (tmr_err_id[0] | tmr_err_id[1]) : '0;
  assign dmr_error_o    = (mode_i == safe_pkg::MODE_DMR) && (|dmr_err);

endmodule

// ==== hdl/resp_steer.sv ====
// Returns bus responses to the harts
// Isolated harts see their isolator; all others see their own or the master port
`timescale 1ns/1ps
`include "safe_defs.svh"

module resp_steer (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  safe_pkg::route_e [`SAFE_NHARTS-1:0]   route_i,
  input  safe_pkg::hart_mask_t                   isolate_i,
  input  safe_pkg::hart_mask_t                   master_i,
  input  safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] hart_instr_req_i,
  input  safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] hart_data_req_i,
  input  safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0] bus_instr_rsp_i,
  input  safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0] bus_data_rsp_i,
  output safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0] hart_instr_rsp_o,
  output safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0] hart_data_rsp_o
);

  // Index 0 is instruction, 1 is data
  safe_pkg::bus_req_t [1:0][`SAFE_NHARTS-1:0] hart_req;
  safe_pkg::bus_rsp_t [1:0][`SAFE_NHARTS-1:0] bus_rsp;
  safe_pkg::bus_rsp_t [1:0][`SAFE_NHARTS-1:0] hart_rsp;

  assign hart_req[0] = hart_instr_req_i;
  assign hart_req[1] = hart_data_req_i;
  assign bus_rsp[0]  = bus_instr_rsp_i;
  assign bus_rsp[1]  = bus_data_rsp_i;

  for (genvar ch = 0; ch < 2; ch++) begin : gen_chan
    safe_pkg::bus_rsp_t master_rsp;

    always_comb begin
      master_rsp = '0;
      for (int h = 0; h < `SAFE_NHARTS; h++) begin
        if (master_i[h]) begin
          master_rsp = bus_rsp[ch][h];
        end
      end
    end

    for (genvar h = 0; h < `SAFE_NHARTS; h++) begin : gen_hart
      safe_pkg::bus_rsp_t live_rsp;
      safe_pkg::bus_rsp_t iso_rsp;

      // What the hart sees when not isolated
      assign live_rsp = (route_i[h] == safe_pkg::ROUTE_MASTER) ? master_rsp : bus_rsp[ch][h];

      wfi_isolator #(
        .ISO_RDATA ((ch == 0) ? `SAFE_WFI_INSN : `SAFE_ISO_DATA)
      ) u_wfi_isolator (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .active_i  (isolate_i[h]),
        .req_i     (hart_req[ch][h]),
        .bus_rsp_i (live_rsp),
        .rsp_o     (iso_rsp)
      );

      assign hart_rsp[ch][h] = (route_i[h] == safe_pkg::ROUTE_ISOLATE) ? iso_rsp : live_rsp;
    end
  end

  assign hart_instr_rsp_o = hart_rsp[0];
  assign hart_data_rsp_o  = hart_rsp[1];

endmodule

// ==== hdl/safe_cpu_wrapper.sv ====
// Bus side of the triple-hart safety wrapper
// Request and response paths are combinational; no buffering, no added handshake
// mode_i and dmr_pair_i should only change while the harts are quiet
`timescale 1ns/1ps
`include "safe_defs.svh"

module safe_cpu_wrapper (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  safe_pkg::redund_mode_e                 mode_i,
  input  safe_pkg::hart_mask_t                   master_i,
  input  safe_pkg::hart_mask_t                   dmr_pair_i,
  input  safe_pkg::hart_mask_t                   sleep_i,
  input  safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] hart_instr_req_i,
  input  safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] hart_data_req_i,
  output safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0] hart_instr_rsp_o,
  output safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0] hart_data_rsp_o,
  output safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] bus_instr_req_o,
  output safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] bus_data_req_o,
  input  safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0] bus_instr_rsp_i,
  input  safe_pkg::bus_rsp_t [`SAFE_NHARTS-1:0] bus_data_rsp_i,
  output logic                                   tmr_error_o,
  output safe_pkg::hart_mask_t                   tmr_error_id_o,
  output logic                                   dmr_error_o
);

  safe_pkg::hart_mask_t                 master;
  safe_pkg::route_e [`SAFE_NHARTS-1:0] route;
  safe_pkg::hart_mask_t                 isolate;

  redundancy_ctrl u_redundancy_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .mode_i     (mode_i),
    .master_i   (master_i),
    .dmr_pair_i (dmr_pair_i),
    .sleep_i    (sleep_i),
    .master_o   (master),
    .route_o    (route),
    .isolate_o  (isolate)
  );

  req_steer u_req_steer (
    .mode_i           (mode_i),
    .master_i         (master),
    .dmr_pair_i       (dmr_pair_i),
    .hart_instr_req_i (hart_instr_req_i),
    .hart_data_req_i  (hart_data_req_i),
    .bus_instr_req_o  (bus_instr_req_o),
    .bus_data_req_o   (bus_data_req_o),
    .tmr_error_o      (tmr_error_o),
    .tmr_error_id_o   (tmr_error_id_o),
    .dmr_error_o      (dmr_error_o)
  );

  resp_steer u_resp_steer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .route_i          (route),
    .isolate_i        (isolate),
    .master_i         (master),
    .hart_instr_req_i (hart_instr_req_i),
    .hart_data_req_i  (hart_data_req_i),
    .bus_instr_rsp_i  (bus_instr_rsp_i),
    .bus_data_rsp_i   (bus_data_rsp_i),
    .hart_instr_rsp_o (hart_instr_rsp_o),
    .hart_data_rsp_o  (hart_data_rsp_o)
  );

endmodule

// ==== hdl/safe_defs.svh ====
// Build constants for the triple-hart safety wrapper
// Hart count is fixed at three because majority voting needs three inputs
// Bus widths are shared by the instruction and data channels
`ifndef SAFE_DEFS_SVH
`define SAFE_DEFS_SVH

// Harts behind the wrapper
`define SAFE_NHARTS 3

// OBI widths
`define SAFE_ADDR_W 32
`define SAFE_DATA_W 32
`define SAFE_BE_W   (`SAFE_DATA_W / 8)

// Read data seen by an isolated hart
// RISC-V wfi keeps the fetch side parked
`define SAFE_WFI_INSN 32'h1050_0073
`define SAFE_ISO_DATA 32'h0000_0000

// Master mask out of reset, hart 0
`define SAFE_MASTER_RST 3'b001

`endif

// ==== hdl/safe_pkg.sv ====
// Shared bus and control types for the safety wrapper
// Requests and responses carry the OBI core signals only, no attributes
`include "safe_defs.svh"

package safe_pkg;

  // One OBI request channel
  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [`SAFE_BE_W-1:0]   be;
    logic [`SAFE_ADDR_W-1:0] addr;
    logic [`SAFE_DATA_W-1:0] wdata;
  } bus_req_t;

  // One OBI response channel
  typedef struct packed {
    logic                    gnt;
    logic                    rvalid;
    logic [`SAFE_DATA_W-1:0] rdata;
  } bus_rsp_t;

  // One bit per hart
  typedef logic [`SAFE_NHARTS-1:0] hart_mask_t;

  typedef enum logic [1:0] {
    MODE_INDEP = 2'd0,
    MODE_TMR   = 2'd1,
    MODE_DMR   = 2'd2
  } redund_mode_e;

  // Where a hart takes its response from
  typedef enum logic [1:0] {
    ROUTE_OWN     = 2'd0,
    ROUTE_MASTER  = 2'd1,
    ROUTE_ISOLATE = 2'd2
  } route_e;

endpackage

// ==== hdl/tmr_voter.sv ====
// Bitwise two-of-three vote over whole OBI requests
// The dissenter id compares complete requests, so it stays zero when all three differ
`timescale 1ns/1ps
`include "safe_defs.svh"

module tmr_voter (
  input  safe_pkg::bus_req_t [`SAFE_NHARTS-1:0] req_i,
  output safe_pkg::bus_req_t                    voted_o,
  output logic                                  error_o,
  output safe_pkg::hart_mask_t                  error_id_o
);

  logic eq_01;
  logic eq_02;
  logic eq_12;

  // Majority per bit
  assign voted_o = (req_i[0] & req_i[1]) |
                   (req_i[0] & req_i[2]) |
                   (req_i[1] & req_i[2]);

  assign eq_01 = (req_i[0] == req_i[1]);
  assign eq_02 = (req_i[0] == req_i[2]);
  assign eq_12 = (req_i[1] == req_i[2]);

  assign error_o = !(eq_01 && eq_12);

  // Odd one out when the other two agree
  assign error_id_o[0] = !eq_01 && !eq_02 &&  eq_12;
  assign error_id_o[1] = !eq_01 &&  eq_02 && !eq_12;
  assign error_id_o[2] =  eq_01 && !eq_02 && !eq_12;

  // At most one dissenter, and only together with the mismatch flag
  always_comb begin
    a_single_dissenter: assert final ($onehot0(error_id_o) &&
                                      (error_o || (error_id_o == '0)))
      else $error("tmr_voter: bad dissenter id %b", error_id_o);
  end

endmodule

// ==== hdl/wfi_isolator.sv ====
// Stand-in OBI slave for a hart cut off from the bus
// Tracks one outstanding access on the real bus, not a deeper pipeline
// Responses still due when isolation ends are dropped
`timescale 1ns/1ps
`include "safe_defs.svh"

module wfi_isolator #(
  parameter logic [`SAFE_DATA_W-1:0] ISO_RDATA = `SAFE_ISO_DATA
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               active_i,
  input  safe_pkg::bus_req_t req_i,
  input  safe_pkg::bus_rsp_t bus_rsp_i,
  output safe_pkg::bus_rsp_t rsp_o
);

  // Answer for our own grant
  logic iso_rvalid_q;
  // Real-bus access still waiting for its rvalid
  logic pend_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      iso_rvalid_q <= 1'b0;
      pend_q       <= 1'b0;
    end else if (active_i) begin
      iso_rvalid_q <= req_i.req;
      pend_q       <= 1'b0;
    end else begin
      iso_rvalid_q <= 1'b0;
      // Set on an accepted access, cleared once the bus answers
      pend_q       <= (req_i.req & bus_rsp_i.gnt) | (pend_q & ~bus_rsp_i.rvalid);
    end
  end

  // Immediate grant while isolated
  assign rsp_o.gnt    = active_i & req_i.req;
  assign rsp_o.rvalid = iso_rvalid_q | pend_q;
  assign rsp_o.rdata  = ISO_RDATA;

  // Every rvalid answers a grant or an open access of the previous cycle
  a_rvalid_has_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_o.rvalid |-> $past(rsp_o.gnt || pend_q || (req_i.req && bus_rsp_i.gnt)));

endmodule

// ==== verif/tb_safe_cpu_wrapper.sv ====
// Self-checking testbench for the bus side of the safety wrapper
// Bus slaves are random response generators, not memories
// Requires mode and dmr_pair changes only between test phases
`timescale 1ns/1ps
`include "safe_defs.svh"

module tb_safe_cpu_wrapper;

  localparam int NH           = `SAFE_NHARTS;
  localparam int CLK_PERIOD   = 10;
  localparam int RST_CYCLES   = 5;
  localparam int INDEP_CYCLES = 40;
  localparam int TMR_CYCLES   = 40;
  localparam int DMR_CYCLES   = 30;
  localparam int SWAP_CYCLES  = 24;
  localparam int RUN_CYCLES   = RST_CYCLES + INDEP_CYCLES + TMR_CYCLES + 3 * DMR_CYCLES +
                                SWAP_CYCLES + 2;
  localparam int WD_MARGIN    = 50;

  typedef safe_pkg::bus_req_t [NH-1:0] req_vec_t;
  typedef safe_pkg::bus_rsp_t [NH-1:0] rsp_vec_t;

  // Expected DUT outputs for one cycle, channel 0 is instruction
  typedef struct packed {
    req_vec_t [1:0]       bus_req;
    rsp_vec_t [1:0]       hart_rsp;
    logic                 tmr_error;
    safe_pkg::hart_mask_t tmr_error_id;
    logic                 dmr_error;
  } expect_t;

  logic                   clk_i;
  logic                   rst_ni;
  safe_pkg::redund_mode_e mode;
  safe_pkg::hart_mask_t   master;
  safe_pkg::hart_mask_t   dmr_pair;
  safe_pkg::hart_mask_t   sleep;
  req_vec_t [1:0]         hart_req;
  rsp_vec_t [1:0]         bus_rsp;
  rsp_vec_t               hart_instr_rsp;
  rsp_vec_t               hart_data_rsp;
  req_vec_t               bus_instr_req;
  req_vec_t               bus_data_req;
  logic                   tmr_error;
  safe_pkg::hart_mask_t   tmr_error_id;
  logic                   dmr_error;

  // Reference state: latched master, isolator rvalid due, open real-bus access
  safe_pkg::hart_mask_t   exp_master;
  logic [1:0][NH-1:0]     iso_rv_q;
  logic [1:0][NH-1:0]     pend_q;
  expect_t                exp_now;
  req_vec_t [1:0]         got_req;
  rsp_vec_t [1:0]         got_rsp;

  safe_cpu_wrapper u_safe_cpu_wrapper (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .mode_i           (mode),
    .master_i         (master),
    .dmr_pair_i       (dmr_pair),
    .sleep_i          (sleep),
    .hart_instr_req_i (hart_req[0]),
    .hart_data_req_i  (hart_req[1]),
    .hart_instr_rsp_o (hart_instr_rsp),
    .hart_data_rsp_o  (hart_data_rsp),
    .bus_instr_req_o  (bus_instr_req),
    .bus_data_req_o   (bus_data_req),
    .bus_instr_rsp_i  (bus_rsp[0]),
    .bus_data_rsp_i   (bus_rsp[1]),
    .tmr_error_o      (tmr_error),
    .tmr_error_id_o   (tmr_error_id),
    .dmr_error_o      (dmr_error)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_req(input string name, input safe_pkg::bus_req_t got,
                           input safe_pkg::bus_req_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      abort_run("bus request differs from the reference");
    end
  endtask

  task automatic check_rsp(input string name, input safe_pkg::bus_rsp_t got,
                           input safe_pkg::bus_rsp_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      abort_run("hart response differs from the reference");
    end
  endtask

  task automatic check_mask(input string name, input safe_pkg::hart_mask_t got,
                            input safe_pkg::hart_mask_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      abort_run("hart mask differs from the reference");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      abort_run("error flag differs from the reference");
    end
  endtask

  // Expected outputs from the routing rules
  function automatic expect_t predict(input safe_pkg::redund_mode_e md,
                                      input safe_pkg::hart_mask_t mst,
                                      input safe_pkg::hart_mask_t pair,
                                      input req_vec_t [1:0] req,
                                      input rsp_vec_t [1:0] rsp,
                                      input logic [1:0][NH-1:0] iso_rv);
    expect_t            e;
    int                 m;
    int                 p;
    int                 cnt;
    safe_pkg::bus_req_t voted;
    e = '0;
    m = 0;
    p = 0;
    for (int h = 0; h < NH; h++) begin
      if (mst[h]) m = h;
      if (pair[h] && !mst[h]) p = h;
    end
    for (int ch = 0; ch < 2; ch++) begin
      // Two of three per bit
      for (int b = 0; b < $bits(safe_pkg::bus_req_t); b++) begin
        cnt = 0;
        for (int h = 0; h < NH; h++) begin
          if (req[ch][h][b]) cnt++;
        end
        voted[b] = (cnt >= 2);
      end
      if (md == safe_pkg::MODE_TMR) begin
        if (req[ch][0] != req[ch][1] || req[ch][1] != req[ch][2]) e.tmr_error = 1'b1;
        for (int h = 0; h < NH; h++) begin
          // Other two agree, this one does not
          if (req[ch][(h + 1) % NH] == req[ch][(h + 2) % NH] &&
              req[ch][h] != req[ch][(h + 1) % NH]) e.tmr_error_id[h] = 1'b1;
        end
      end
      if (md == safe_pkg::MODE_DMR && req[ch][m] != req[ch][p]) e.dmr_error = 1'b1;
      for (int h = 0; h < NH; h++) begin
        if (md == safe_pkg::MODE_INDEP) begin
          e.bus_req[ch][h]  = req[ch][h];
          e.hart_rsp[ch][h] = rsp[ch][h];
        end else begin
          if (h == m) begin
            e.bus_req[ch][h] = (md == safe_pkg::MODE_TMR) ? voted : req[ch][m];
          end
          if (md == safe_pkg::MODE_TMR || pair[h]) begin
            e.hart_rsp[ch][h] = rsp[ch][m];
          end else begin
            // Isolated hart answered locally
            e.hart_rsp[ch][h].gnt    = req[ch][h].req;
            e.hart_rsp[ch][h].rvalid = iso_rv[ch][h];
            e.hart_rsp[ch][h].rdata  = (ch == 0) ? `SAFE_WFI_INSN : `SAFE_ISO_DATA;
          end
        end
      end
    end
    return e;
  endfunction

  // Compare mid-cycle, then advance the reference to the next rising edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      exp_master = `SAFE_MASTER_RST;
      iso_rv_q   = '0;
      pend_q     = '0;
    end else begin
      got_req[0] = bus_instr_req;
      got_req[1] = bus_data_req;
      got_rsp[0] = hart_instr_rsp;
      got_rsp[1] = hart_data_rsp;
      exp_now = predict(mode, exp_master, dmr_pair, hart_req, bus_rsp, iso_rv_q | pend_q);
      for (int ch = 0; ch < 2; ch++) begin
        for (int h = 0; h < NH; h++) begin
          check_req($sformatf("bus_%s_req_o[%0d]", (ch == 0) ? "instr" : "data", h),
                    got_req[ch][h], exp_now.bus_req[ch][h]);
          check_rsp($sformatf("hart_%s_rsp_o[%0d]", (ch == 0) ? "instr" : "data", h),
                    got_rsp[ch][h], exp_now.hart_rsp[ch][h]);
          if (mode == safe_pkg::MODE_DMR && !dmr_pair[h]) begin
            iso_rv_q[ch][h] = hart_req[ch][h].req;
            pend_q[ch][h]   = 1'b0;
          end else begin
            iso_rv_q[ch][h] = 1'b0;
            pend_q[ch][h]   = (hart_req[ch][h].req && exp_now.hart_rsp[ch][h].gnt) ||
                              (pend_q[ch][h] && !exp_now.hart_rsp[ch][h].rvalid);
          end
        end
      end
      check_flag("tmr_error_o", tmr_error, exp_now.tmr_error);
      check_mask("tmr_error_id_o", tmr_error_id, exp_now.tmr_error_id);
      check_flag("dmr_error_o", dmr_error, exp_now.dmr_error);
      if (&sleep) exp_master = master;
    end
  end

  function automatic safe_pkg::bus_req_t rand_req();
    safe_pkg::bus_req_t r;
    logic [31:0]        a;
    a       = $urandom;
    r.req   = a[0] | a[1];
    r.we    = a[2];
    r.be    = a[6:3];
    r.addr  = $urandom;
    r.wdata = $urandom;
    return r;
  endfunction

  function automatic safe_pkg::bus_rsp_t rand_rsp();
    safe_pkg::bus_rsp_t r;
    logic [31:0]        a;
    a        = $urandom;
    r.gnt    = a[0] | a[1];
    r.rvalid = a[2];
    r.rdata  = $urandom;
    return r;
  endfunction

  function automatic safe_pkg::bus_req_t flip_bit(input safe_pkg::bus_req_t r);
    int idx;
    idx    = $urandom % $bits(safe_pkg::bus_req_t);
    r[idx] = ~r[idx];
    return r;
  endfunction

  // One cycle of lockstep traffic; odd marks the hart that deviates, NH for none
  task automatic drive_lockstep(input int odd);
    safe_pkg::bus_req_t base;
    for (int ch = 0; ch < 2; ch++) begin
      base = rand_req();
      for (int h = 0; h < NH; h++) begin
        hart_req[ch][h] = (h == odd) ? flip_bit(base) : base;
        bus_rsp[ch][h]  = rand_rsp();
      end
    end
  endtask

  // DMR traffic, isolated hart random, partner deviating now and then
  task automatic run_dmr(input safe_pkg::hart_mask_t pair, input int mst);
    int partner;
    partner  = 0;
    for (int h = 0; h < NH; h++) begin
      if (pair[h] && h != mst) partner = h;
    end
    mode     = safe_pkg::MODE_DMR;
    dmr_pair = pair;
    repeat (DMR_CYCLES) begin
      drive_lockstep(($urandom % 4 == 0) ? partner : NH);
      for (int h = 0; h < NH; h++) begin
        if (!pair[h]) begin
          hart_req[0][h] = rand_req();
          hart_req[1][h] = rand_req();
        end
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  initial begin
    int unsigned seed_draw;
    seed_draw = $urandom(32'hb805_82f0);
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    mode      = safe_pkg::MODE_INDEP;
    master    = 3'b001;
    dmr_pair  = 3'b011;
    sleep     = '0;
    hart_req  = '0;
    bus_rsp   = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Straight pass-through
    repeat (INDEP_CYCLES) begin
      for (int ch = 0; ch < 2; ch++) begin
        for (int h = 0; h < NH; h++) begin
          hart_req[ch][h] = rand_req();
          bus_rsp[ch][h]  = rand_rsp();
        end
      end
      @(posedge clk_i);
      #1;
    end

    // Voting with at most one corrupted hart
    mode = safe_pkg::MODE_TMR;
    repeat (TMR_CYCLES) begin
      drive_lockstep($urandom % 4);
      @(posedge clk_i);
      #1;
    end

    run_dmr(3'b011, 0);
    run_dmr(3'b101, 0);

    // Master moves to hart 1 only across the all-asleep cycle
    mode   = safe_pkg::MODE_TMR;
    master = 3'b010;
    for (int c = 0; c < SWAP_CYCLES; c++) begin
      sleep = (c == SWAP_CYCLES / 3) ? 3'b111 : 3'($urandom % 7);
      if (c > SWAP_CYCLES / 2) master = 3'b100;
      drive_lockstep(NH);
      @(posedge clk_i);
      #1;
    end
    sleep = '0;

    run_dmr(3'b110, 1);

    @(posedge clk_i);
    #1;
    $display("All checks passed");
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (RUN_CYCLES + WD_MARGIN));
    abort_run("watchdog expired before the test sequence finished");
  end

endmodule
